/* common/mldsa_sampler_pkg.sv */
/*
 * Shared constants, vector typedefs and memory request/response structs
 * for the ML-DSA rejection sampler subsystem
 */
`default_nettype none

package mldsa_sampler_pkg;

  // Modulus and sampler geometry
  localparam int unsigned MLDSA_Q         = 8380417;
  localparam int unsigned NUM_SAMPLERS    = 5;
  localparam int unsigned SAMPLE_W        = 24;
  localparam int unsigned COEFF_W         = 23;
  localparam int unsigned COEFFS_PER_WORD = 4;
  localparam int unsigned POLY_WORDS      = 64;
  localparam int unsigned ADDR_W          = 6;

  typedef logic [SAMPLE_W-1:0]                 sample_t;
  typedef logic [COEFF_W-1:0]                  coeff_t;
  typedef logic [ADDR_W-1:0]                   mem_addr_t;
  // Coefficient 0 sits in the low bits
  typedef logic [COEFFS_PER_WORD*COEFF_W-1:0]  mem_word_t;

  // One memory access, write when we is set
  typedef struct packed {
    logic      we;
    mem_addr_t addr;
    mem_word_t wdata;
  } mem_req_t;

  // Read data returned to the host
  typedef struct packed {
    logic      valid;
    mem_word_t data;
  } rd_rsp_t;

endpackage

`default_nettype wire

/* rej_sampler/rej_sampler.sv */
/*
 * Single-candidate rejection check against the modulus
 */
`timescale 1ns/1ps
`default_nettype none

module rej_sampler #(
  parameter int unsigned REJ_VALUE = mldsa_sampler_pkg::MLDSA_Q
) (
  input  logic                      valid_i,
  input  mldsa_sampler_pkg::sample_t data_i,
  output logic                      valid_o,
  output mldsa_sampler_pkg::coeff_t  data_o
);

  mldsa_sampler_pkg::coeff_t cand;

  // Top bit of the candidate is discarded
  assign cand = data_i[mldsa_sampler_pkg::COEFF_W-1:0];

  // Keep only values strictly below the modulus
  assign valid_o = valid_i && (cand < REJ_VALUE);
  assign data_o  = cand;

endmodule

`default_nettype wire

/* rej_sampler/sample_buffer.sv */
/*
 * Compacting sample buffer
 * Takes up to NUM_WR masked samples per cycle, releases NUM_RD at once
 */
`timescale 1ns/1ps
`default_nettype none

module sample_buffer #(
  parameter int unsigned NUM_WR       = 5,
  parameter int unsigned NUM_RD       = 4,
  parameter int unsigned BUFFER_DEPTH = 12
) (
  input  logic                                   clk,
  input  logic                                   rst_n_i,
  input  logic                                   zeroize_i,
  // Input side
  input  logic [NUM_WR-1:0]                      data_valid_i,
  input  mldsa_sampler_pkg::coeff_t [NUM_WR-1:0] data_i,
  output logic                                   buffer_full_o,
  // Output side, consumer always accepts
  output logic                                   data_valid_o,
  output mldsa_sampler_pkg::coeff_t [NUM_RD-1:0] data_o
);

  localparam int unsigned CNT_W = $clog2(BUFFER_DEPTH + 1);

  typedef logic [CNT_W-1:0] cnt_t;

  mldsa_sampler_pkg::coeff_t buf_q [BUFFER_DEPTH];
  mldsa_sampler_pkg::coeff_t buf_d [BUFFER_DEPTH];
  cnt_t                      cnt_q;
  cnt_t                      cnt_d;
  logic                      rd_en;

  // Release a group as soon as enough entries are stored
  assign rd_en        = (int'(cnt_q) >= NUM_RD);
  assign data_valid_o = rd_en;

  // Oldest entries live at the bottom of the array
  always_comb begin
    for (int i = 0; i < NUM_RD; i++) begin
      data_o[i] = buf_q[i];
    end
  end

  // Upstream must hold when a full input beat would not fit
  assign buffer_full_o = (int'(cnt_q) > (BUFFER_DEPTH - NUM_WR));

  always_comb begin
    buf_d = buf_q;
    cnt_d = cnt_q;
    // Drop the released group and shift the rest down
    if (rd_en) begin
      for (int i = 0; i < BUFFER_DEPTH - NUM_RD; i++) begin
        buf_d[i] = buf_q[i + NUM_RD];
      end
      cnt_d = cnt_q - cnt_t'(NUM_RD);
    end
    // Append valid lanes in ascending order, skipping gaps
    for (int j = 0; j < NUM_WR; j++) begin
      if (data_valid_i[j] && (int'(cnt_d) < BUFFER_DEPTH)) begin
        buf_d[cnt_d] = data_i[j];
        cnt_d        = cnt_d + cnt_t'(1);
      end
    end
  end

  // Fill count
  always_ff @(posedge clk) begin
    if (!rst_n_i || zeroize_i) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  // Sample storage
  always_ff @(posedge clk) begin
    buf_q <= buf_d;
  end

endmodule

`default_nettype wire

/* rej_sampler/rej_sampler_ctrl.sv */
/*
 * Rejection sampler array feeding the compacting buffer
 * Input hold strobe and packed memory word output
 */
`timescale 1ns/1ps
`default_nettype none

module rej_sampler_ctrl #(
  parameter int unsigned REJ_VALUE    = mldsa_sampler_pkg::MLDSA_Q,
  parameter int unsigned BUFFER_DEPTH = 12
) (
  input  logic                                                   clk,
  input  logic                                                   rst_n_i,
  input  logic                                                   zeroize_i,
  // Candidate stream
  input  logic                                                   data_valid_i,
  output logic                                                   data_hold_o,
  input  mldsa_sampler_pkg::sample_t [mldsa_sampler_pkg::NUM_SAMPLERS-1:0] data_i,
  // Packed coefficient groups
  output logic                                                   data_valid_o,
  output mldsa_sampler_pkg::mem_word_t                           data_o
);

  localparam int unsigned NS = mldsa_sampler_pkg::NUM_SAMPLERS;
  localparam int unsigned NR = mldsa_sampler_pkg::COEFFS_PER_WORD;
  localparam int unsigned CW = mldsa_sampler_pkg::COEFF_W;

  logic                                beat_valid;
  logic [NS-1:0]                       lane_valid;
  mldsa_sampler_pkg::coeff_t [NS-1:0]  lane_data;
  mldsa_sampler_pkg::coeff_t [NR-1:0]  group;
  logic                                buffer_full;

  // Beat only counts while the buffer has room
  assign data_hold_o = buffer_full;
  assign beat_valid  = data_valid_i && !buffer_full;

  for (genvar g = 0; g < NS; g++) begin : g_lane
    rej_sampler #(
      .REJ_VALUE(REJ_VALUE)
    ) i_rej_sampler (
      .valid_i(beat_valid),
      .data_i (data_i[g]),
      .valid_o(lane_valid[g]),
      .data_o (lane_data[g])
    );
  end

  sample_buffer #(
    .NUM_WR      (NS),
    .NUM_RD      (NR),
    .BUFFER_DEPTH(BUFFER_DEPTH)
  ) i_sample_buffer (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .zeroize_i    (zeroize_i),
    .data_valid_i (lane_valid),
    .data_i       (lane_data),
    .buffer_full_o(buffer_full),
    .data_valid_o (data_valid_o),
    .data_o       (group)
  );

  // Coefficient 0 goes to the low bits of the word
  always_comb begin
    for (int i = 0; i < NR; i++) begin
      data_o[i*CW +: CW] = group[i];
    end
  end

endmodule

`default_nettype wire

/* src/poly_writer.sv */
/*
 * Polynomial writer
 * Turns coefficient groups into sequential memory writes, flags done
 */
`timescale 1ns/1ps
`default_nettype none

module poly_writer (
  input  logic                         clk,
  input  logic                         rst_n_i,
  input  logic                         zeroize_i,
  input  logic                         start_i,
  input  logic                         data_valid_i,
  input  mldsa_sampler_pkg::mem_word_t data_i,
  output mldsa_sampler_pkg::mem_req_t  wr_req_o,
  output logic                         done_o
);

  localparam mldsa_sampler_pkg::mem_addr_t LAST_ADDR =
    mldsa_sampler_pkg::mem_addr_t'(mldsa_sampler_pkg::POLY_WORDS - 1);

  logic                         active_q;
  logic                         done_q;
  mldsa_sampler_pkg::mem_addr_t addr_q;
  logic                         wr_en;

  // Groups outside an active fill are dropped
  assign wr_en = active_q && data_valid_i;

  assign wr_req_o.we    = wr_en;
  assign wr_req_o.addr  = addr_q;
  assign wr_req_o.wdata = data_i;
  assign done_o         = done_q;

  always_ff @(posedge clk) begin
    if (!rst_n_i || zeroize_i) begin
      active_q <= 1'b0;
      done_q   <= 1'b0;
      addr_q   <= '0;
    end else if (start_i) begin
      // New polynomial restarts at word 0
      active_q <= 1'b1;
      done_q   <= 1'b0;
      addr_q   <= '0;
    end else if (wr_en) begin
      addr_q <= addr_q + mldsa_sampler_pkg::mem_addr_t'(1);
      // Last word closes the polynomial
      if (addr_q == LAST_ADDR) begin
        active_q <= 1'b0;
        done_q   <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* src/poly_mem.sv */
/*
 * Single-port synchronous polynomial memory
 */
`timescale 1ns/1ps
`default_nettype none

module poly_mem #(
  parameter int unsigned DEPTH = 64
) (
  input  logic                         clk,
  input  mldsa_sampler_pkg::mem_req_t  req_i,
  output mldsa_sampler_pkg::mem_word_t rdata_o
);

  mldsa_sampler_pkg::mem_word_t mem [DEPTH];
  mldsa_sampler_pkg::mem_word_t rdata_q;

  // Write or read each cycle, never both
  always_ff @(posedge clk) begin
    if (req_i.we) begin
      mem[req_i.addr] <= req_i.wdata;
    end else begin
      rdata_q <= mem[req_i.addr];
    end
  end

  // Read data appears the cycle after the address
  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

/* src/poly_mem_arbiter.sv */
/*
 * Polynomial memory arbiter
 * Writer has fixed priority, host read waits in a one-deep slot
 */
`timescale 1ns/1ps
`default_nettype none

module poly_mem_arbiter (
  input  logic                         clk,
  input  logic                         rst_n_i,
  input  logic                         zeroize_i,
  input  mldsa_sampler_pkg::mem_req_t  wr_req_i,
  input  logic                         rd_req_i,
  input  mldsa_sampler_pkg::mem_addr_t rd_addr_i,
  output mldsa_sampler_pkg::mem_req_t  mem_req_o,
  input  mldsa_sampler_pkg::mem_word_t mem_rdata_i,
  output mldsa_sampler_pkg::rd_rsp_t   rd_rsp_o
);

  logic                         pend_q;
  mldsa_sampler_pkg::mem_addr_t pend_addr_q;
  logic                         rd_issue;
  logic                         issued_q;

  // Read goes out only in a cycle the writer leaves free
  assign rd_issue = pend_q && !wr_req_i.we;

  always_comb begin
    if (wr_req_i.we) begin
      mem_req_o = wr_req_i;
    end else begin
      mem_req_o.we    = 1'b0;
      mem_req_o.addr  = pend_addr_q;
      mem_req_o.wdata = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i || zeroize_i) begin
      pend_q   <= 1'b0;
      issued_q <= 1'b0;
    end else begin
      // Host keeps at most one request outstanding
      if (rd_req_i) begin
        pend_q <= 1'b1;
      end else if (rd_issue) begin
        pend_q <= 1'b0;
      end
      issued_q <= rd_issue;
    end
  end

  // Address is payload
  always_ff @(posedge clk) begin
    if (rd_req_i) begin
      pend_addr_q <= rd_addr_i;
    end
  end

  // Memory data is ready one cycle after the read is issued
  assign rd_rsp_o.valid = issued_q;
  assign rd_rsp_o.data  = mem_rdata_i;

endmodule

`default_nettype wire

/* src/mldsa_sampler_top.sv */
/*
 * ML-DSA rejection sampler subsystem top level
 * Sampler, polynomial writer, arbiter and memory
 */
`timescale 1ns/1ps
`default_nettype none

module mldsa_sampler_top #(
  parameter int unsigned REJ_VALUE    = mldsa_sampler_pkg::MLDSA_Q,
  parameter int unsigned BUFFER_DEPTH = 12
) (
  input  logic                                                   clk,
  input  logic                                                   rst_n_i,
  input  logic                                                   zeroize_i,
  input  logic                                                   start_i,
  // Squeezed hash stream
  input  logic                                                   data_valid_i,
  output logic                                                   data_hold_o,
  input  mldsa_sampler_pkg::sample_t [mldsa_sampler_pkg::NUM_SAMPLERS-1:0] data_i,
  output logic                                                   done_o,
  // Host read port
  input  logic                                                   rd_req_i,
  input  mldsa_sampler_pkg::mem_addr_t                           rd_addr_i,
  output mldsa_sampler_pkg::rd_rsp_t                             rd_rsp_o
);

  logic                         grp_valid;
  mldsa_sampler_pkg::mem_word_t grp_data;
  mldsa_sampler_pkg::mem_req_t  wr_req;
  mldsa_sampler_pkg::mem_req_t  mem_req;
  mldsa_sampler_pkg::mem_word_t mem_rdata;

  rej_sampler_ctrl #(
    .REJ_VALUE   (REJ_VALUE),
    .BUFFER_DEPTH(BUFFER_DEPTH)
  ) i_rej_sampler_ctrl (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .zeroize_i   (zeroize_i),
    .data_valid_i(data_valid_i),
    .data_hold_o (data_hold_o),
    .data_i      (data_i),
    .data_valid_o(grp_valid),
    .data_o      (grp_data)
  );

  poly_writer i_poly_writer (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .zeroize_i   (zeroize_i),
    .start_i     (start_i),
    .data_valid_i(grp_valid),
    .data_i      (grp_data),
    .wr_req_o    (wr_req),
    .done_o      (done_o)
  );

  poly_mem_arbiter i_poly_mem_arbiter (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .zeroize_i  (zeroize_i),
    .wr_req_i   (wr_req),
    .rd_req_i   (rd_req_i),
    .rd_addr_i  (rd_addr_i),
    .mem_req_o  (mem_req),
    .mem_rdata_i(mem_rdata),
    .rd_rsp_o   (rd_rsp_o)
  );

  poly_mem #(
    .DEPTH(mldsa_sampler_pkg::POLY_WORDS)
  ) i_poly_mem (
    .clk    (clk),
    .req_i  (mem_req),
    .rdata_o(mem_rdata)
  );

endmodule

`default_nettype wire

/* dv/mldsa_sampler_props.sv */
/*
 * Concurrent assertions on the sampler subsystem top-level ports
 * Bound to the top level
 */
`timescale 1ns/1ps
`default_nettype none

module mldsa_sampler_props (
  input logic                       clk,
  input logic                       rst_n_i,
  input logic                       zeroize_i,
  input logic                       start_i,
  input logic                       data_hold_o,
  input logic                       done_o,
  input logic                       rd_req_i,
  input mldsa_sampler_pkg::rd_rsp_t rd_rsp_o
);

  logic rd_open_q;
  logic started_q;

  // Host read outstanding between request and response
  always_ff @(posedge clk) begin
    if (!rst_n_i || zeroize_i) begin
      rd_open_q <= 1'b0;
    end else if (rd_req_i) begin
      rd_open_q <= 1'b1;
    end else if (rd_rsp_o.valid) begin
      rd_open_q <= 1'b0;
    end
  end

  // Start seen since the last reset or zeroize
  always_ff @(posedge clk) begin
    if (!rst_n_i || zeroize_i) begin
      started_q <= 1'b0;
    end else if (start_i) begin
      started_q <= 1'b1;
    end
  end

  a_rsp_after_req : assert property (@(posedge clk) disable iff (!rst_n_i)
    $rose(rd_rsp_o.valid) |-> rd_open_q)
    else $error("read response without an outstanding request");

  a_done_after_start : assert property (@(posedge clk) disable iff (!rst_n_i)
    $rose(done_o) |-> started_q)
    else $error("done rose without a start");

  // Buffer is empty right out of reset
  a_hold_low_out_of_reset : assert property (@(posedge clk)
    $rose(rst_n_i) |-> !data_hold_o)
    else $error("hold high out of reset");

endmodule

bind mldsa_sampler_top mldsa_sampler_props i_mldsa_sampler_props (.*);

`default_nettype wire

/* dv/mldsa_sampler_tb.sv */
/*
 * Testbench for the ML-DSA rejection sampler subsystem
 * Clock, reset, hash stream model, directed tests, compare tasks and summary
 */
`timescale 1ns/1ps
`default_nettype none

module mldsa_sampler_tb;

  localparam int unsigned NS      = mldsa_sampler_pkg::NUM_SAMPLERS;
  localparam int unsigned CW      = mldsa_sampler_pkg::COEFF_W;
  localparam int unsigned NC      = mldsa_sampler_pkg::COEFFS_PER_WORD;
  localparam int unsigned Q       = mldsa_sampler_pkg::MLDSA_Q;
  // Count of 23-bit values at or above Q
  localparam int unsigned ABOVE_Q = (1 << CW) - Q;
  localparam int          TIMEOUT = 4000;

  logic                                clk;
  logic                                rst_n_i;
  logic                                zeroize_i;
  logic                                start_i;
  logic                                data_valid_i;
  logic                                data_hold_o;
  mldsa_sampler_pkg::sample_t [NS-1:0] data_i;
  logic                                done_o;
  logic                                rd_req_i;
  mldsa_sampler_pkg::mem_addr_t        rd_addr_i;
  mldsa_sampler_pkg::rd_rsp_t          rd_rsp_o;

  // Kept coefficients of the current polynomial, stream order
  mldsa_sampler_pkg::coeff_t ref_q[$];
  string                     cur_test;
  int                        n_tests;
  int                        n_checks;
  int                        n_errors;
  int                        test_errors;
  logic                      hold_seen;
  logic                      rej_seen;
  logic                      top_seen;

  mldsa_sampler_top i_mldsa_sampler_top (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Drive point sits 2 ns after the rising edge
  task automatic tick();
    @(posedge clk);
    #2;
  endtask

  task automatic timeout_fail(input string what);
    $display("ERROR: %s timed out waiting for %s", cur_test, what);
    $display("TEST FAIL");
    $finish;
  endtask

  task automatic compare_word(input string what, input mldsa_sampler_pkg::mem_word_t exp,
                              input mldsa_sampler_pkg::mem_word_t act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      test_errors++;
      $display("FAILED %s %s: expected %h, actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic compare_bit(input string what, input logic exp, input logic act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      test_errors++;
      $display("FAILED %s %s: expected %b, actual %b", cur_test, what, exp, act);
    end
  endtask

  task automatic begin_test(input string name);
    cur_test    = name;
    test_errors = 0;
    n_tests++;
  endtask

  task automatic end_test();
    if (test_errors == 0) begin
      $display("test %s: ok", cur_test);
    end else begin
      $display("test %s: %0d errors", cur_test, test_errors);
    end
  endtask

  // Mode 0 keeps every candidate, mode 1 mixes in rejects and bit 23
  function automatic mldsa_sampler_pkg::sample_t make_sample(input int mode);
    mldsa_sampler_pkg::sample_t s;
    int unsigned                v;
    if (mode == 0) begin
      v = $urandom % Q;
      s = mldsa_sampler_pkg::sample_t'(v);
    end else begin
      if ($urandom % 2) begin
        v = Q + ($urandom % ABOVE_Q);
      end else begin
        v = $urandom % Q;
      end
      s     = mldsa_sampler_pkg::sample_t'(v);
      s[CW] = $urandom % 2;
    end
    return s;
  endfunction

  // Word k holds reference coefficients 4k..4k+3, coefficient 0 low
  function automatic mldsa_sampler_pkg::mem_word_t expected_word(input int k);
    mldsa_sampler_pkg::mem_word_t w;
    for (int i = 0; i < NC; i++) begin
      w[i*CW +: CW] = ref_q[k*NC + i];
    end
    return w;
  endfunction

  task automatic clear_state();
    zeroize_i = 1'b1;
    tick();
    zeroize_i = 1'b0;
    tick();
    ref_q.delete();
    hold_seen = 1'b0;
    rej_seen  = 1'b0;
    top_seen  = 1'b0;
  endtask

  task automatic wait_done();
    int cycles;
    cycles = 0;
    while (!done_o) begin
      if (cycles >= TIMEOUT) timeout_fail("done");
      tick();
      cycles++;
    end
  endtask

  // Start a polynomial, then present beats and keep each one while hold is high
  task automatic run_stream(input int mode, input int max_beats, input bit to_done);
    mldsa_sampler_pkg::sample_t [NS-1:0] beat;
    mldsa_sampler_pkg::coeff_t           c;
    logic                                have_beat;
    int                                  beats;
    int                                  cycles;
    start_i = 1'b1;
    tick();
    start_i   = 1'b0;
    have_beat = 1'b0;
    beats     = 0;
    cycles    = 0;
    while ((beats < max_beats) && !done_o) begin
      if (cycles >= TIMEOUT) timeout_fail("stream to finish");
      if (!have_beat) begin
        for (int l = 0; l < NS; l++) begin
          beat[l] = make_sample(mode);
        end
        have_beat = 1'b1;
      end
      // Beat stays on the bus until a cycle without hold takes it
      data_i       = beat;
      data_valid_i = 1'b1;
      if (data_hold_o) begin
        hold_seen = 1'b1;
      end else begin
        for (int l = 0; l < NS; l++) begin
          c = beat[l][CW-1:0];
          if (beat[l][CW]) top_seen = 1'b1;
          // Clear bit 23, keep if below Q
          if (c < Q) begin
            ref_q.push_back(c);
          end else begin
            rej_seen = 1'b1;
          end
        end
        have_beat = 1'b0;
        beats++;
      end
      tick();
      cycles++;
    end
    data_valid_i = 1'b0;
    if (to_done) wait_done();
  endtask

  task automatic read_word(input mldsa_sampler_pkg::mem_addr_t addr,
                           output mldsa_sampler_pkg::mem_word_t data);
    int cycles;
    rd_addr_i = addr;
    rd_req_i  = 1'b1;
    tick();
    rd_req_i  = 1'b0;
    cycles    = 0;
    // Latency varies with writer traffic
    while (!rd_rsp_o.valid) begin
      if (cycles >= TIMEOUT) timeout_fail("read response");
      tick();
      cycles++;
    end
    data = rd_rsp_o.data;
  endtask

  task automatic check_memory();
    mldsa_sampler_pkg::mem_word_t d;
    if (ref_q.size() < mldsa_sampler_pkg::POLY_WORDS * NC) begin
      n_errors++;
      test_errors++;
      $display("ERROR: %s stream gave only %0d kept coefficients", cur_test, ref_q.size());
    end else begin
      for (int k = 0; k < mldsa_sampler_pkg::POLY_WORDS; k++) begin
        read_word(mldsa_sampler_pkg::mem_addr_t'(k), d);
        compare_word($sformatf("word %0d", k), expected_word(k), d);
      end
    end
  endtask

  // Reads spread over the polynomial while the writer is still busy
  task automatic read_during_fill();
    mldsa_sampler_pkg::mem_addr_t addr;
    mldsa_sampler_pkg::mem_word_t d;
    int                           cycles;
    for (int k = 0; k < 8; k++) begin
      addr   = mldsa_sampler_pkg::mem_addr_t'(k * 9);
      cycles = 0;
      while (ref_q.size() < NC * (int'(addr) + 1)) begin
        if (cycles >= TIMEOUT) timeout_fail("coefficients for a read");
        tick();
        cycles++;
      end
      // Buffer drains a word within 3 cycles of acceptance
      repeat (5) tick();
      read_word(addr, d);
      compare_word($sformatf("word %0d", addr), expected_word(int'(addr)), d);
    end
  endtask

  initial begin
    void'($urandom(57));
    rst_n_i      = 1'b0;
    zeroize_i    = 1'b0;
    start_i      = 1'b0;
    data_valid_i = 1'b0;
    data_i       = '0;
    rd_req_i     = 1'b0;
    rd_addr_i    = '0;
    n_tests      = 0;
    n_checks     = 0;
    n_errors     = 0;
    repeat (10) @(posedge clk);
    #2;
    rst_n_i = 1'b1;
    tick();

    begin_test("reset");
    compare_bit("hold", 1'b0, data_hold_o);
    compare_bit("done", 1'b0, done_o);
    compare_bit("read valid", 1'b0, rd_rsp_o.valid);
    end_test();

    // 52 beats of 5 give the 256 coefficients
    begin_test("accept_all");
    clear_state();
    run_stream(0, 52, 1'b1);
    check_memory();
    compare_bit("done held", 1'b1, done_o);
    end_test();

    begin_test("rejection");
    clear_state();
    run_stream(1, TIMEOUT, 1'b1);
    compare_bit("rejects seen", 1'b1, rej_seen);
    compare_bit("bit 23 seen", 1'b1, top_seen);
    check_memory();
    end_test();

    begin_test("backpressure");
    clear_state();
    run_stream(0, TIMEOUT, 1'b1);
    compare_bit("hold seen", 1'b1, hold_seen);
    check_memory();
    end_test();

    begin_test("read_during_write");
    clear_state();
    fork
      run_stream(1, TIMEOUT, 1'b1);
      read_during_fill();
    join
    end_test();

    // Previous fill left done high
    begin_test("zeroize");
    compare_bit("done before zeroize", 1'b1, done_o);
    clear_state();
    compare_bit("done after zeroize", 1'b0, done_o);
    // 105 coefficients leave one behind in the buffer
    run_stream(0, 21, 1'b0);
    compare_bit("done mid polynomial", 1'b0, done_o);
    clear_state();
    run_stream(0, TIMEOUT, 1'b1);
    check_memory();
    end_test();

    $display("tests: %0d, checks: %0d, errors: %0d", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* mldsa_sampler.f */
common/mldsa_sampler_pkg.sv
rej_sampler/rej_sampler.sv
rej_sampler/sample_buffer.sv
rej_sampler/rej_sampler_ctrl.sv
src/poly_writer.sv
src/poly_mem.sv
src/poly_mem_arbiter.sv
src/mldsa_sampler_top.sv
dv/mldsa_sampler_props.sv
dv/mldsa_sampler_tb.sv

/* Bender.yml */
package:
  name: mldsa_sampler

sources:
  - common/mldsa_sampler_pkg.sv
  - rej_sampler/rej_sampler.sv
  - rej_sampler/sample_buffer.sv
  - rej_sampler/rej_sampler_ctrl.sv
  - src/poly_writer.sv
  - src/poly_mem.sv
  - src/poly_mem_arbiter.sv
  - src/mldsa_sampler_top.sv
  - target: test
    files:
      - dv/mldsa_sampler_props.sv
      - dv/mldsa_sampler_tb.sv
